//--- common/soc_pkg.sv
package soc_pkg;

	// host bus widths
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// shared data RAM, byte addresses 0x000 to 0x3FF
	localparam int ram_words = 256;
	localparam int ram_idx_w = $clog2(ram_words);

	// host window onto the RAM
	localparam logic [addr_w-1:0] mem_window_base = 32'h0000_0400;
	localparam logic [addr_w-1:0] mem_window_size = ram_words * 4;

	// register map, upper address bits must be zero
	typedef enum logic [7:0] {
		reg_ctrl     = 8'h00,
		reg_status   = 8'h04,
		reg_op_addr  = 8'h08,
		reg_res_addr = 8'h0C,
		reg_result0  = 8'h10,
		reg_result1  = 8'h14,
		reg_result2  = 8'h18,
		reg_result3  = 8'h1C
	} reg_offset_e;

	localparam logic [1:0] axi_resp_okay   = 2'b00;
	localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage

//--- common/mm_pkg.sv
package mm_pkg;

	localparam int op_w = 128;

	// two guard bits, acc + B + N stays below 4N
	localparam int acc_w = op_w + 2;

	localparam int op_words = 4;
	localparam int word_sel_w = $clog2(op_words);

	// A at op_addr, B at op_addr+16, N at op_addr+32
	localparam int fetch_words = 3 * op_words;

	localparam int mm_iters = op_w;
	localparam int cnt_w = $clog2(mm_iters);

	typedef enum logic [2:0] {
		idle,
		fetch,
		run,
		reduce,
		write_back,
		finish
	} mm_state_e;

endpackage

//--- hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
	input  logic                         clk,
	input  logic                         en,
	input  logic                         we,
	input  logic [soc_pkg::ram_idx_w-1:0] index,
	input  logic [soc_pkg::data_w-1:0]    wdata,
	output logic [soc_pkg::data_w-1:0]    rdata
);
	import soc_pkg::*;

	logic [data_w-1:0] mem [ram_words];

	// read data registered, held between reads
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          host_ren,
	input  logic                          host_wen,
	input  logic [soc_pkg::addr_w-1:0]    host_addr,
	input  logic [soc_pkg::data_w-1:0]    host_wdata,
	output logic                          host_done,
	output logic [soc_pkg::data_w-1:0]    host_rdata,

	input  logic                          eng_ren,
	input  logic                          eng_wen,
	input  logic [soc_pkg::addr_w-1:0]    eng_addr,
	input  logic [soc_pkg::data_w-1:0]    eng_wdata,
	output logic                          eng_done,
	output logic [soc_pkg::data_w-1:0]    eng_rdata,

	output logic                          ram_en,
	output logic                          ram_we,
	output logic [soc_pkg::ram_idx_w-1:0] ram_index,
	output logic [soc_pkg::data_w-1:0]    ram_wdata,
	input  logic [soc_pkg::data_w-1:0]    ram_rdata
);
	import soc_pkg::*;

	logic host_req;
	logic eng_req;
	logic grant_host;
	logic grant_eng;
	logic pending;
	logic owner_eng;
	logic last_eng;

	assign host_req = host_ren | host_wen;
	assign eng_req  = eng_ren | eng_wen;

	// no new grant while a transfer completes
	// on a tie the side not served last wins
	assign grant_eng  = !pending && eng_req && (!host_req || !last_eng);
	assign grant_host = !pending && host_req && !grant_eng;

	assign ram_en    = grant_eng | grant_host;
	assign ram_we    = grant_eng ? eng_wen : host_wen;
	assign ram_index = grant_eng ? eng_addr[ram_idx_w+1:2] : host_addr[ram_idx_w+1:2];
	assign ram_wdata = grant_eng ? eng_wdata : host_wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= 1'b0;
			owner_eng <= 1'b0;
			last_eng  <= 1'b0;
		end else begin
			pending <= ram_en;
			if (ram_en) begin
				owner_eng <= grant_eng;
				last_eng  <= grant_eng;
			end
		end
	end

	assign host_done  = pending && !owner_eng;
	assign eng_done   = pending && owner_eng;
	assign host_rdata = ram_rdata;
	assign eng_rdata  = ram_rdata;

endmodule

//--- hdl/axil_regs.sv
`timescale 1ns/1ps

module axil_regs (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [soc_pkg::addr_w-1:0] awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [soc_pkg::data_w-1:0] wdata,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [soc_pkg::addr_w-1:0] araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [soc_pkg::data_w-1:0] rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,

	output logic                       start,
	output logic [soc_pkg::addr_w-1:0] op_addr,
	output logic [soc_pkg::addr_w-1:0] res_addr,
	input  logic [mm_pkg::op_w-1:0]    result,
	input  logic                       busy,
	input  logic                       done,

	output logic                       mem_ren,
	output logic                       mem_wen,
	output logic [soc_pkg::addr_w-1:0] mem_addr,
	output logic [soc_pkg::data_w-1:0] mem_wdata,
	input  logic                       mem_done,
	input  logic [soc_pkg::data_w-1:0] mem_rdata
);
	import soc_pkg::*;
	import mm_pkg::*;

	typedef enum logic [2:0] {
		ax_idle,
		ax_mem_wr,
		ax_mem_rd,
		ax_bresp,
		ax_rresp
	} axil_state_e;

	axil_state_e       state;
	logic              wr_take;
	logic              rd_take;
	logic [addr_w-1:0] wr_off;
	logic [addr_w-1:0] rd_off;
	logic              wr_in_win;
	logic              rd_in_win;
	logic              done_flag;
	logic [op_w-1:0]   result_q;
	logic [data_w-1:0] reg_rdata;

	function automatic logic reg_mapped(input logic [addr_w-1:0] addr);
		logic hit;
		hit = 1'b0;
		if (addr[addr_w-1:8] == '0) begin
			case (addr[7:0])
				reg_ctrl, reg_status, reg_op_addr, reg_res_addr,
				reg_result0, reg_result1, reg_result2, reg_result3: hit = 1'b1;
				default: hit = 1'b0;
			endcase
		end
		return hit;
	endfunction

	// ###################################################################
	// address phase, AW and W only together, writes before reads

	assign wr_take = (state == ax_idle) && awvalid && wvalid;
	assign rd_take = (state == ax_idle) && arvalid && !(awvalid && wvalid);

	assign awready = wr_take;
	assign wready  = wr_take;
	assign arready = rd_take;

	// below the base the offset wraps and misses the window
	assign wr_off    = awaddr - mem_window_base;
	assign rd_off    = araddr - mem_window_base;
	assign wr_in_win = wr_off < mem_window_size;
	assign rd_in_win = rd_off < mem_window_size;

	always_comb begin
		reg_rdata = '0;
		case (araddr[7:0])
			reg_status:   reg_rdata = data_w'({done_flag, busy | start});
			reg_op_addr:  reg_rdata = op_addr;
			reg_res_addr: reg_rdata = res_addr;
			reg_result0:  reg_rdata = result_q[0*data_w +: data_w];
			reg_result1:  reg_rdata = result_q[1*data_w +: data_w];
			reg_result2:  reg_rdata = result_q[2*data_w +: data_w];
			reg_result3:  reg_rdata = result_q[3*data_w +: data_w];
			default:      reg_rdata = '0;
		endcase
	end

	// ###################################################################
	// control FSM and registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ax_idle;
			start     <= 1'b0;
			done_flag <= 1'b0;
			bresp     <= axi_resp_okay;
			rresp     <= axi_resp_okay;
			op_addr   <= '0;
			res_addr  <= '0;
		end else begin
			start <= 1'b0;
			if (start) begin
				done_flag <= 1'b0;
			end
			if (done) begin
				done_flag <= 1'b1;
			end
			case (state)
				ax_idle: begin
					if (wr_take) begin
						if (wr_in_win) begin
							state <= ax_mem_wr;
						end else begin
							state <= ax_bresp;
							bresp <= reg_mapped(awaddr) ? axi_resp_okay : axi_resp_slverr;
							if (reg_mapped(awaddr)) begin
								case (awaddr[7:0])
									reg_ctrl:     start <= wdata[0];
									reg_op_addr:  op_addr <= wdata;
									reg_res_addr: res_addr <= wdata;
									default: ;
								endcase
							end
						end
					end else if (rd_take) begin
						if (rd_in_win) begin
							state <= ax_mem_rd;
						end else begin
							state <= ax_rresp;
							rresp <= reg_mapped(araddr) ? axi_resp_okay : axi_resp_slverr;
						end
					end
				end
				ax_mem_wr: begin
					if (mem_done) begin
						bresp <= axi_resp_okay;
						state <= ax_bresp;
					end
				end
				ax_mem_rd: begin
					if (mem_done) begin
						rresp <= axi_resp_okay;
						state <= ax_rresp;
					end
				end
				ax_bresp: begin
					if (bready) begin
						state <= ax_idle;
					end
				end
				ax_rresp: begin
					if (rready) begin
						state <= ax_idle;
					end
				end
				default: state <= ax_idle;
			endcase
		end
	end

	// payload, window read data replaces the register value
	always_ff @(posedge clk) begin
		if (wr_take) begin
			mem_addr  <= wr_off;
			mem_wdata <= wdata;
		end else if (rd_take) begin
			mem_addr <= rd_off;
		end
		if (rd_take) begin
			rdata <= reg_rdata;
		end else if (state == ax_mem_rd && mem_done) begin
			rdata <= mem_rdata;
		end
		if (done) begin
			result_q <= result;
		end
	end

	assign mem_ren = (state == ax_mem_rd);
	assign mem_wen = (state == ax_mem_wr);
	assign bvalid  = (state == ax_bresp);
	assign rvalid  = (state == ax_rresp);

endmodule

//--- mont_mul/mont_mul.sv
`timescale 1ns/1ps

module mont_mul (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic                       start,
	input  logic [soc_pkg::addr_w-1:0] op_addr,
	input  logic [soc_pkg::addr_w-1:0] res_addr,

	output logic                       lsu_ren,
	output logic                       lsu_wen,
	output logic [soc_pkg::addr_w-1:0] lsu_addr,
	output logic [soc_pkg::data_w-1:0] lsu_wdata,
	input  logic                       lsu_done,
	input  logic [soc_pkg::data_w-1:0] lsu_rdata,

	output logic [mm_pkg::op_w-1:0]    result,
	output logic                       busy,
	output logic                       done
);
	import soc_pkg::*;
	import mm_pkg::*;

	mm_state_e                       state;
	logic [cnt_w-1:0]                cnt;
	logic [word_sel_w-1:0]           word_idx;
	logic [addr_w-1:0]               op_base;
	logic [addr_w-1:0]               res_base;
	logic [op_words-1:0][data_w-1:0] a_w;
	logic [op_words-1:0][data_w-1:0] b_w;
	logic [op_words-1:0][data_w-1:0] n_w;
	logic [acc_w-1:0]                acc;
	logic [acc_w-1:0]                sum_b;
	logic [acc_w-1:0]                sum_n;
	logic [acc_w-1:0]                acc_step;
	logic [acc_w-1:0]                acc_red;

	assign word_idx = cnt[word_sel_w-1:0];

	// ###################################################################
	// datapath, one bit of A per cycle

	always_comb begin
		sum_b    = acc + (a_w[0][0] ? acc_w'(b_w) : '0);
		// make the sum even before halving
		sum_n    = sum_b + (sum_b[0] ? acc_w'(n_w) : '0);
		acc_step = sum_n >> 1;
		acc_red  = (acc >= acc_w'(n_w)) ? acc - acc_w'(n_w) : acc;
	end

	// operands and bases
	always_ff @(posedge clk) begin
		if (state == idle && start) begin
			op_base  <= op_addr;
			res_base <= res_addr;
		end
		if (state == fetch && lsu_done) begin
			case (cnt[cnt_w-1:word_sel_w])
				'd0:     a_w[word_idx] <= lsu_rdata;
				'd1:     b_w[word_idx] <= lsu_rdata;
				default: n_w[word_idx] <= lsu_rdata;
			endcase
		end else if (state == run) begin
			a_w <= a_w >> 1;
		end
	end

	// ###################################################################
	// sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			cnt   <= '0;
			acc   <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= fetch;
						cnt   <= '0;
						acc   <= '0;
					end
				end
				fetch: begin
					if (lsu_done) begin
						if (cnt == cnt_w'(fetch_words - 1)) begin
							cnt   <= '0;
							state <= run;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				run: begin
					acc <= acc_step;
					cnt <= cnt + 1'b1;
					if (cnt == cnt_w'(mm_iters - 1)) begin
						cnt   <= '0;
						state <= reduce;
					end
				end
				reduce: begin
					acc   <= acc_red;
					state <= write_back;
				end
				write_back: begin
					if (lsu_done) begin
						if (cnt == cnt_w'(op_words - 1)) begin
							cnt   <= '0;
							state <= finish;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				finish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// word address from the counter, low word first
	assign lsu_addr  = (state == write_back ? res_base : op_base) + addr_w'({cnt, 2'b00});
	assign lsu_wdata = acc[word_idx*data_w +: data_w];
	assign lsu_ren   = (state == fetch);
	assign lsu_wen   = (state == write_back);

	assign result = acc[op_w-1:0];
	assign busy   = (state != idle);
	assign done   = (state == finish);

endmodule

//--- hdl/mont_sys_top.sv
`timescale 1ns/1ps

module mont_sys_top (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [soc_pkg::addr_w-1:0] awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [soc_pkg::data_w-1:0] wdata,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [soc_pkg::addr_w-1:0] araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [soc_pkg::data_w-1:0] rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready
);
	import soc_pkg::*;
	import mm_pkg::*;

	// engine control
	logic                 start;
	logic                 busy;
	logic                 done;
	logic [addr_w-1:0]    op_addr;
	logic [addr_w-1:0]    res_addr;
	logic [op_w-1:0]      result;

	// host load/store port
	logic                 host_ren;
	logic                 host_wen;
	logic [addr_w-1:0]    host_addr;
	logic [data_w-1:0]    host_wdata;
	logic                 host_done;
	logic [data_w-1:0]    host_rdata;

	// engine load/store port
	logic                 eng_ren;
	logic                 eng_wen;
	logic [addr_w-1:0]    eng_addr;
	logic [data_w-1:0]    eng_wdata;
	logic                 eng_done;
	logic [data_w-1:0]    eng_rdata;

	logic                 ram_en;
	logic                 ram_we;
	logic [ram_idx_w-1:0] ram_index;
	logic [data_w-1:0]    ram_wdata;
	logic [data_w-1:0]    ram_rdata;

	axil_regs axil_regs_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.start     (start),
		.op_addr   (op_addr),
		.res_addr  (res_addr),
		.result    (result),
		.busy      (busy),
		.done      (done),
		.mem_ren   (host_ren),
		.mem_wen   (host_wen),
		.mem_addr  (host_addr),
		.mem_wdata (host_wdata),
		.mem_done  (host_done),
		.mem_rdata (host_rdata)
	);

	mont_mul mont_mul_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.op_addr   (op_addr),
		.res_addr  (res_addr),
		.lsu_ren   (eng_ren),
		.lsu_wen   (eng_wen),
		.lsu_addr  (eng_addr),
		.lsu_wdata (eng_wdata),
		.lsu_done  (eng_done),
		.lsu_rdata (eng_rdata),
		.result    (result),
		.busy      (busy),
		.done      (done)
	);

	mem_arbiter mem_arbiter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.host_ren   (host_ren),
		.host_wen   (host_wen),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_done  (host_done),
		.host_rdata (host_rdata),
		.eng_ren    (eng_ren),
		.eng_wen    (eng_wen),
		.eng_addr   (eng_addr),
		.eng_wdata  (eng_wdata),
		.eng_done   (eng_done),
		.eng_rdata  (eng_rdata),
		.ram_en     (ram_en),
		.ram_we     (ram_we),
		.ram_index  (ram_index),
		.ram_wdata  (ram_wdata),
		.ram_rdata  (ram_rdata)
	);

	data_ram data_ram_i (
		.clk   (clk),
		.en    (ram_en),
		.we    (ram_we),
		.index (ram_index),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

endmodule

//--- tb/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

localparam int wait_limit = 1000;

// AW and W together, then bready held low for a few cycles
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
	output logic [1:0] resp);
	int cycles;
	int hold;
	hold = $urandom_range(0, 4);
	@(negedge clk);
	awaddr  = addr;
	awvalid = 1'b1;
	wdata   = data;
	wvalid  = 1'b1;
	cycles  = 0;
	do begin
		@(posedge clk);
		cycles++;
		if (cycles > wait_limit) fail_run("timeout waiting for awready and wready");
	end while (!(awready && wready));
	@(negedge clk);
	awvalid = 1'b0;
	wvalid  = 1'b0;
	cycles  = 0;
	while (!bvalid) begin
		@(negedge clk);
		cycles++;
		if (cycles > wait_limit) fail_run("timeout waiting for bvalid");
	end
	repeat (hold) @(negedge clk);
	resp   = bresp;
	bready = 1'b1;
	@(negedge clk);
	bready = 1'b0;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	int cycles;
	int hold;
	hold = $urandom_range(0, 4);
	@(negedge clk);
	araddr  = addr;
	arvalid = 1'b1;
	cycles  = 0;
	do begin
		@(posedge clk);
		cycles++;
		if (cycles > wait_limit) fail_run("timeout waiting for arready");
	end while (!arready);
	@(negedge clk);
	arvalid = 1'b0;
	cycles  = 0;
	while (!rvalid) begin
		@(negedge clk);
		cycles++;
		if (cycles > wait_limit) fail_run("timeout waiting for rvalid");
	end
	repeat (hold) @(negedge clk);
	data   = rdata;
	resp   = rresp;
	rready = 1'b1;
	@(negedge clk);
	rready = 1'b0;
endtask

// full product first, then divide by 2^128 mod n bit by bit
function automatic logic [127:0] mont_ref(input logic [127:0] a, input logic [127:0] b,
	input logic [127:0] n);
	logic [256:0] prod;
	logic [256:0] addend;
	prod   = '0;
	addend = {129'd0, b};
	for (int i = 0; i < 128; i++) begin
		if (a[i]) prod = prod + addend;
		addend = addend << 1;
	end
	for (int i = 0; i < 128; i++) begin
		if (prod[0]) prod = prod + {129'd0, n};
		prod = prod >> 1;
	end
	// below 2n here
	if (prod >= {129'd0, n}) prod = prod - {129'd0, n};
	return prod[127:0];
endfunction

`endif

//--- tb/tb_mont_sys.sv
`timescale 1ns/1ps

module tb_mont_sys;
	import soc_pkg::*;

	logic              clk;
	logic              rst_n;
	logic [addr_w-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [data_w-1:0] wdata;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [addr_w-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [data_w-1:0] rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;

	mont_sys_top mont_sys_top_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	`include "tb_axil_tasks.svh"

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else fail_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, act));
	endtask

	task automatic write_ok(input logic [31:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		check_value("bresp", 32'(axi_resp_okay), 32'(resp));
	endtask

	task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
		input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read(addr, data, resp);
		check_value("rresp", 32'(axi_resp_okay), 32'(resp));
		check_value(name, exp, data);
	endtask

	// read request held while the write response waits on bready
	task automatic read_behind_bresp(input logic [31:0] addr, input logic [31:0] data);
		int cycles;
		int hold;
		hold = $urandom_range(2, 5);
		@(negedge clk);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wvalid  = 1'b1;
		cycles  = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > wait_limit) fail_run("timeout waiting for awready and wready");
		end while (!(awready && wready));
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		araddr  = addr;
		arvalid = 1'b1;
		repeat (hold) @(negedge clk);
		check_value("bvalid", 32'h1, 32'(bvalid));
		check_value("bresp", 32'(axi_resp_okay), 32'(bresp));
		bready = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > wait_limit) fail_run("timeout waiting for arready");
		end while (!arready);
		@(negedge clk);
		bready  = 1'b0;
		arvalid = 1'b0;
		cycles  = 0;
		while (!rvalid) begin
			@(negedge clk);
			cycles++;
			if (cycles > wait_limit) fail_run("timeout waiting for rvalid");
		end
		check_value("rresp", 32'(axi_resp_okay), 32'(rresp));
		check_value("rdata", data, rdata);
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	function automatic logic [127:0] rand_wide();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// ##################################################################
	// one complete job through the register map

	task automatic run_job(input logic [31:0] op, input logic [31:0] res,
		input logic [127:0] a, input logic [127:0] b, input logic [127:0] n,
		input bit contend, input bit restart);
		logic [127:0] exp_res;
		logic [31:0]  rd;
		logic [1:0]   resp;
		int           polls;
		exp_res = mont_ref(a, b, n);
		for (int i = 0; i < 4; i++) begin
			write_ok(mem_window_base + op + 32'(i * 4), a[i*32 +: 32]);
			write_ok(mem_window_base + op + 32'(16 + i * 4), b[i*32 +: 32]);
			write_ok(mem_window_base + op + 32'(32 + i * 4), n[i*32 +: 32]);
		end
		write_ok(32'(reg_op_addr), op);
		write_ok(32'(reg_res_addr), res);
		write_ok(32'(reg_ctrl), 32'h1);
		// host reads racing the operand fetch
		if (contend) begin
			for (int i = 0; i < 4; i++) begin
				read_expect(mem_window_base + op + 32'(32 + i * 4), n[i*32 +: 32],
					"rdata of N word");
			end
		end
		if (restart) begin
			read_expect(32'(reg_status), 32'h1, "status before restart");
			// a taken restart would fetch from the moved base
			write_ok(32'(reg_op_addr), op + 32'h40);
			write_ok(32'(reg_ctrl), 32'h1);
		end
		polls = 0;
		rd    = '0;
		while (!rd[1]) begin
			axil_read(32'(reg_status), rd, resp);
			check_value("rresp", 32'(axi_resp_okay), 32'(resp));
			if (!rd[1]) check_value("status busy", 32'h1, 32'(rd[0]));
			polls++;
			if (polls > 300) fail_run("timeout waiting for the done bit in STATUS");
		end
		check_value("status", 32'h2, rd);
		for (int i = 0; i < 4; i++) begin
			read_expect(32'(reg_result0) + 32'(i * 4), exp_res[i*32 +: 32],
				$sformatf("result%0d", i));
			read_expect(mem_window_base + res + 32'(i * 4), exp_res[i*32 +: 32],
				$sformatf("written result word %0d", i));
		end
		// operands left as written
		for (int i = 0; i < 4; i++) begin
			read_expect(mem_window_base + op + 32'(i * 4), a[i*32 +: 32], "A word");
			read_expect(mem_window_base + op + 32'(16 + i * 4), b[i*32 +: 32], "B word");
			read_expect(mem_window_base + op + 32'(32 + i * 4), n[i*32 +: 32], "N word");
		end
		read_expect(32'(reg_status), 32'h2, "status after readout");
	endtask

	// ##################################################################
	// response channel checks

	bresp_held: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else fail_run("bvalid dropped or bresp changed while bready was low");

	rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else fail_run("rvalid dropped or read data changed while rready was low");

	no_accept_while_resp: assert property (@(posedge clk) disable iff (!rst_n)
		(awready || arready) |-> !bvalid && !rvalid)
		else fail_run("an address was accepted while a response was pending");

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		int           base;
		int           idx [8];
		logic [31:0]  words [8];
		logic [31:0]  rd;
		logic [1:0]   resp;
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] n;
		void'($urandom(90));
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("bvalid", 32'h0, 32'(bvalid));
		check_value("rvalid", 32'h0, 32'(rvalid));
		read_expect(32'(reg_status), 32'h0, "status after reset");

		// window round trip at scattered addresses
		base = $urandom_range(0, 255);
		for (int i = 0; i < 8; i++) begin
			idx[i]   = (base + i * 29) % 256;
			words[i] = $urandom;
			write_ok(mem_window_base + 32'(idx[i] * 4), words[i]);
		end
		for (int i = 0; i < 8; i++) begin
			read_expect(mem_window_base + 32'(idx[i] * 4), words[i], "window word");
		end
		axil_read(32'h20, rd, resp);
		check_value("rresp", 32'(axi_resp_slverr), 32'(resp));
		axil_read(32'h800, rd, resp);
		check_value("rresp", 32'(axi_resp_slverr), 32'(resp));

		// read address presented during a pending write response
		read_behind_bresp(32'(reg_op_addr), $urandom);

		n      = rand_wide() | 128'h1;
		n[127] = 1'b1;
		a      = rand_wide() % n;
		b      = rand_wide() % n;
		run_job(32'h040, 32'h0A0, a, b, n, 1'b0, 1'b0);

		n = rand_wide() | 128'h1;
		a = rand_wide() % n;
		b = rand_wide() % n;
		run_job(32'h300, 32'h0C0, a, b, n, 1'b1, 1'b1);

		// largest operands
		n      = rand_wide() | 128'h1;
		n[127] = 1'b1;
		run_job(32'h180, 32'h1E0, n - 128'd1, n - 128'd1, n, 1'b1, 1'b0);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+tb
common/soc_pkg.sv
common/mm_pkg.sv
hdl/data_ram.sv
hdl/mem_arbiter.sv
hdl/axil_regs.sv
mont_mul/mont_mul.sv
hdl/mont_sys_top.sv
tb/tb_mont_sys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the Montgomery subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mont_sys -f all.f -o tb_mont_sys

status=0
./obj_dir/tb_mont_sys > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
